// ==== bench/rvb_vectors.svh ====
`ifndef RVB_VECTORS_SVH
`define RVB_VECTORS_SVH

// Each row holds instruction word, value1, value2, expected decode flag and expected result
typedef struct packed {
	rvb_pkg::insn_t insn;
	rvb_pkg::word_t value1;
	rvb_pkg::word_t value2;
	logic           decoded;
	rvb_pkg::word_t result;
} vector_t;

localparam int num_vectors = 29;

vector_t vectors [num_vectors] = '{
	'{32'h403170B3, 32'hF0F01234, 32'h0FF0FF00, 1'b1, 32'hF0000034}, // ANDN
	'{32'h403160B3, 32'h12000034, 32'hFFFF0F0F, 1'b1, 32'h1200F0F4}, // ORN
	'{32'h403140B3, 32'hAAAA5555, 32'hA5A5A5A5, 1'b1, 32'hF0F00F0F}, // XNOR
	'{32'h203120B3, 32'h80000001, 32'h00000010, 1'b1, 32'h00000012}, // SH1ADD wraps
	'{32'h203140B3, 32'h00001000, 32'hFFFFFFFF, 1'b1, 32'h00003FFF}, // SH2ADD
	'{32'h203160B3, 32'h12345678, 32'h00000008, 1'b1, 32'h91A2B3C8}, // SH3ADD
	'{32'h0A3140B3, 32'h80000000, 32'h00000000, 1'b1, 32'h80000000}, // MIN
	'{32'h0A3150B3, 32'h80000000, 32'h00000000, 1'b1, 32'h00000000}, // MAX
	'{32'h0A3160B3, 32'h80000000, 32'h00000000, 1'b1, 32'h00000000}, // MINU
	'{32'h0A3170B3, 32'h80000000, 32'h00000000, 1'b1, 32'h80000000}, // MAXU
	'{32'h0A3140B3, 32'hFFFFFFFE, 32'h00000005, 1'b1, 32'hFFFFFFFE}, // MIN of -2 and 5
	'{32'h0A3170B3, 32'hFFFFFFFE, 32'h00000005, 1'b1, 32'hFFFFFFFE}, // MAXU
	'{32'h61211093, 32'h12345678, 32'h00000000, 1'b0, 32'h00000000}, // CRC32.W dropped
	'{32'h603150B3, 32'h12345678, 32'h00000004, 1'b0, 32'h00000000}, // ROR dropped
	'{32'h60011093, 32'h00000000, 32'h00000000, 1'b1, 32'h00000020}, // CLZ of zero
	'{32'h60011093, 32'h00010000, 32'h00000000, 1'b1, 32'h0000000F}, // CLZ
	'{32'h60111093, 32'h00000000, 32'h00000000, 1'b1, 32'h00000020}, // CTZ of zero
	'{32'h60111093, 32'h00010000, 32'h00000000, 1'b1, 32'h00000010}, // CTZ
	'{32'h60211093, 32'hF0F00001, 32'h00000000, 1'b1, 32'h00000009}, // PCNT
	'{32'h60411093, 32'h12345680, 32'h00000000, 1'b1, 32'hFFFFFF80}, // SEXT.B negative
	'{32'h60411093, 32'hFFFFFF7F, 32'h00000000, 1'b1, 32'h0000007F}, // SEXT.B positive
	'{32'h60511093, 32'h00008001, 32'h00000000, 1'b1, 32'hFFFF8001}, // SEXT.H
	'{32'h0A3110B3, 32'h80000000, 32'h00000003, 1'b1, 32'h80000000}, // CLMUL
	'{32'h0A3130B3, 32'h80000000, 32'h00000003, 1'b1, 32'h00000001}, // CLMULH
	'{32'h0A3120B3, 32'h80000000, 32'h00000003, 1'b1, 32'h00000003}, // CLMULR
	'{32'h0A3110B3, 32'hFFFFFFFF, 32'hFFFFFFFF, 1'b1, 32'h55555555}, // Square spreads the bits
	'{32'h0A3130B3, 32'hFFFFFFFF, 32'hFFFFFFFF, 1'b1, 32'h55555555},
	'{32'h0A3120B3, 32'hFFFFFFFF, 32'hFFFFFFFF, 1'b1, 32'hAAAAAAAA},
	'{32'h0A3120B3, 32'hFFFFFFFF, 32'h80000001, 1'b1, 32'hFFFFFFFE}  // Bit 31 cancels
};

`endif

// ==== bench/tb_rvb_unit.sv ====
`timescale 1ns/1ps

module tb_rvb_unit;

	localparam int in_timeout    = 16;
	localparam int out_timeout   = 4 * (1 << $bits(rvb_pkg::clmul_count_t));
	localparam int reject_cycles = 6;

	logic           clk_i;
	logic           rst_i;
	logic           din_valid_i;
	logic           din_ready_o;
	logic           din_decoded_o;
	rvb_pkg::word_t din_value1_i;
	rvb_pkg::word_t din_value2_i;
	rvb_pkg::insn_t din_instruction_i;
	logic           dout_valid_o;
	logic           dout_ready_i;
	rvb_pkg::word_t dout_result_o;

	`include "rvb_vectors.svh"

	logic [15:0]    lfsr_state;
	logic           stalled;
	rvb_pkg::word_t held_result;
	rvb_pkg::word_t expected_q [$];

	rvb_unit u_rvb_unit (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.din_valid_i       (din_valid_i),
		.din_ready_o       (din_ready_o),
		.din_decoded_o     (din_decoded_o),
		.din_value1_i      (din_value1_i),
		.din_value2_i      (din_value2_i),
		.din_instruction_i (din_instruction_i),
		.dout_valid_o      (dout_valid_o),
		.dout_ready_i      (dout_ready_i),
		.dout_result_o     (dout_result_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10]; // x^16+x^14+x^13+x^11+1
		return {state[14:0], feedback};
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input rvb_pkg::word_t actual,
			input rvb_pkg::word_t expected);
		if (actual !== expected) begin
			abort_run($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			abort_run($sformatf("FAIL time=%0t signal=%s expected=%b actual=%b",
				$time, name, expected, actual));
		end
	endtask

	// A stalled output must not move and a new one must be the oldest expected
	task automatic check_output();
		rvb_pkg::word_t expected;
		if (stalled) begin
			check_flag("dout_valid_o", dout_valid_o, 1'b1);
			check_word("dout_result_o", dout_result_o, held_result);
		end else if (dout_valid_o) begin
			if (expected_q.size() == 0) begin
				abort_run("A result appeared with no instruction in flight");
			end else begin
				expected = expected_q.pop_front();
				check_word("dout_result_o", dout_result_o, expected);
			end
		end
		stalled     = dout_valid_o && !dout_ready_i;
		held_result = dout_result_o;
	endtask

	task automatic next_cycle(input logic valid, input vector_t row);
		@(negedge clk_i);
		din_valid_i       = valid;
		din_instruction_i = row.insn;
		din_value1_i      = row.value1;
		din_value2_i      = row.value2;
		lfsr_state        = lfsr_step(lfsr_state);
		dout_ready_i      = lfsr_state[0]; // Random back-pressure
		#2; // Low phase settled
		check_output();
	endtask

	task automatic run_row(input vector_t row);
		int waited;
		waited = 0;
		next_cycle(1'b1, row);
		check_flag("din_decoded_o", din_decoded_o, row.decoded);
		while (!din_ready_o) begin
			waited++;
			if (waited > in_timeout) abort_run("Timed out waiting for din_ready_o");
			next_cycle(1'b1, row);
		end
		expected_q.push_back(row.result); // Accepted on the coming edge
		waited = 0;
		next_cycle(1'b0, row);
		// Busy until the result is loaded into the output register
		while (expected_q.size() != 0) begin
			check_flag("din_ready_o", din_ready_o, 1'b0);
			waited++;
			if (waited > out_timeout) abort_run("Timed out waiting for the result");
			next_cycle(1'b0, row);
		end
		check_flag("din_ready_o", din_ready_o, 1'b1);
	endtask

	task automatic reject_row(input vector_t row);
		for (int n = 0; n < reject_cycles; n++) begin
			next_cycle(1'b1, row);
			check_flag("din_decoded_o", din_decoded_o, row.decoded);
			check_flag("din_ready_o", din_ready_o, 1'b0);
		end
		next_cycle(1'b0, row);
	endtask

	initial begin
		vector_t idle;
		int      waited;
		idle              = '0;
		rst_i             = 1'b1;
		din_valid_i       = 1'b0;
		din_instruction_i = '0;
		din_value1_i      = '0;
		din_value2_i      = '0;
		dout_ready_i      = 1'b0;
		lfsr_state        = 16'd13062;
		stalled           = 1'b0;
		held_result       = '0;
		repeat (10) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		next_cycle(1'b0, idle);
		check_flag("dout_valid_o", dout_valid_o, 1'b0);
		check_flag("din_ready_o", din_ready_o, 1'b0);
		for (int i = 0; i < num_vectors; i++) begin
			if (vectors[i].decoded) begin
				run_row(vectors[i]);
			end else begin
				reject_row(vectors[i]);
			end
		end
		waited = 0;
		while (dout_valid_o) begin
			waited++;
			if (waited > out_timeout) abort_run("Timed out draining the output");
			next_cycle(1'b0, idle);
		end
		next_cycle(1'b0, idle);
		check_flag("dout_valid_o", dout_valid_o, 1'b0);
		$display("No errors");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+bench
src/rvb_pkg.sv
src/rvb_decoder.sv
src/rvb_simple.sv
src/rvb_bitcnt.sv
src/rvb_clmul.sv
src/rvb_result_stage.sv
src/rvb_unit.sv
bench/tb_rvb_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_rvb_unit -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/Vtb_rvb_unit
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation ended with status $sim_status"
	exit $sim_status
fi

exit 0

// ==== src/rvb_bitcnt.sv ====
`timescale 1ns/1ps

module rvb_bitcnt (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           start_i,
	output logic           start_ready_o,
	input  rvb_pkg::op_e   op_i,
	input  rvb_pkg::word_t value1_i,
	input  logic           take_i,
	output logic           done_o,
	output rvb_pkg::word_t result_o
);
	rvb_pkg::word_t clz_cnt;
	rvb_pkg::word_t ctz_cnt;
	rvb_pkg::word_t pop_cnt;
	rvb_pkg::word_t result_d;

	assign start_ready_o = !done_o || take_i;

	always_comb begin
		clz_cnt = rvb_pkg::word_t'(rvb_pkg::xlen);
		ctz_cnt = rvb_pkg::word_t'(rvb_pkg::xlen);
		pop_cnt = '0;
		for (int i = 0; i < rvb_pkg::xlen; i++) begin
			if (value1_i[i]) begin
				clz_cnt = rvb_pkg::word_t'(rvb_pkg::xlen - 1 - i); // Highest one wins
				pop_cnt = pop_cnt + rvb_pkg::word_t'(1);
			end
			if (value1_i[rvb_pkg::xlen - 1 - i]) begin
				ctz_cnt = rvb_pkg::word_t'(rvb_pkg::xlen - 1 - i); // Lowest one wins
			end
		end
	end

	always_comb begin
		case (op_i)
			rvb_pkg::op_clz:   result_d = clz_cnt;
			rvb_pkg::op_ctz:   result_d = ctz_cnt;
			rvb_pkg::op_pcnt:  result_d = pop_cnt;
			rvb_pkg::op_sextb: result_d = {{(rvb_pkg::xlen - 8){value1_i[7]}}, value1_i[7:0]};
			default:           result_d = {{(rvb_pkg::xlen - 16){value1_i[15]}}, value1_i[15:0]};
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			done_o <= 1'b0;
		end else if (start_i && start_ready_o) begin
			done_o <= 1'b1;
		end else if (take_i) begin
			done_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i && start_ready_o) begin
			result_o <= result_d;
		end
	end

	a_bitcnt_done: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(done_o) |->
			$past(start_i && op_i inside {[rvb_pkg::op_clz:rvb_pkg::op_sexth]}));

endmodule

// ==== src/rvb_clmul.sv ====
`timescale 1ns/1ps

module rvb_clmul (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           start_i,
	output logic           start_ready_o,
	input  rvb_pkg::op_e   op_i,
	input  rvb_pkg::word_t value1_i,
	input  rvb_pkg::word_t value2_i,
	input  logic           take_i,
	output logic           done_o,
	output rvb_pkg::word_t result_o
);
	logic                          iterating;
	logic                          last_step;
	rvb_pkg::clmul_count_t         count;
	rvb_pkg::op_e                  op_q;
	rvb_pkg::word_t                multiplier;
	logic [2*rvb_pkg::xlen-1:0]    multiplicand;
	logic [2*rvb_pkg::xlen-1:0]    acc;
	logic [2*rvb_pkg::xlen-1:0]    acc_next;

	assign start_ready_o = !iterating && (!done_o || take_i);
	assign last_step = iterating && count == rvb_pkg::clmul_count_t'(rvb_pkg::xlen - 1);
	assign acc_next = multiplier[0] ? acc ^ multiplicand : acc;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			iterating <= 1'b0;
			done_o    <= 1'b0;
			count     <= '0;
		end else if (start_i && start_ready_o) begin
			iterating <= 1'b1;
			done_o    <= 1'b0; // Previous result taken this edge
			count     <= '0;
		end else if (iterating) begin
			count <= count + rvb_pkg::clmul_count_t'(1);
			if (last_step) begin
				iterating <= 1'b0;
				done_o    <= 1'b1;
			end
		end else if (take_i) begin
			done_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i && start_ready_o) begin
			multiplicand <= {{rvb_pkg::xlen{1'b0}}, value1_i};
			multiplier   <= value2_i;
			acc          <= '0;
			op_q         <= op_i;
		end else if (iterating) begin
			multiplicand <= multiplicand << 1;
			multiplier   <= multiplier >> 1;
			acc          <= acc_next;
		end
		if (last_step) begin
			case (op_q)
				rvb_pkg::op_clmulh: result_o <= acc_next[2*rvb_pkg::xlen-1:rvb_pkg::xlen];
				rvb_pkg::op_clmulr: result_o <= acc_next[2*rvb_pkg::xlen-2:rvb_pkg::xlen-1];
				default:            result_o <= acc_next[rvb_pkg::xlen-1:0];
			endcase
		end
	end

	a_clmul_no_restart: assert property (@(posedge clk_i) disable iff (rst_i)
		iterating |-> !start_i);

endmodule

// ==== src/rvb_decoder.sv ====
`timescale 1ns/1ps

module rvb_decoder (
	input  rvb_pkg::insn_t insn_i,
	output rvb_pkg::unit_e unit_o,
	output rvb_pkg::op_e   op_o
);
	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	logic [4:0] rs2;

	assign opcode = insn_i[6:0];
	assign funct7 = insn_i[31:25];
	assign funct3 = insn_i[14:12];
	assign rs2    = insn_i[24:20];

	always_comb begin
		unit_o = rvb_pkg::unit_none;
		op_o   = rvb_pkg::op_andn; // Don't care when unit is none
		if (opcode == rvb_pkg::opcode_op) begin
			case (funct7)
				rvb_pkg::funct7_andn: begin
					unit_o = rvb_pkg::unit_simple;
					case (funct3)
						rvb_pkg::funct3_andn: op_o = rvb_pkg::op_andn;
						rvb_pkg::funct3_orn:  op_o = rvb_pkg::op_orn;
						rvb_pkg::funct3_xnor: op_o = rvb_pkg::op_xnor;
						default:              unit_o = rvb_pkg::unit_none; // SRA and friends
					endcase
				end
				rvb_pkg::funct7_shadd: begin
					unit_o = rvb_pkg::unit_simple;
					case (funct3)
						rvb_pkg::funct3_sh1add: op_o = rvb_pkg::op_sh1add;
						rvb_pkg::funct3_sh2add: op_o = rvb_pkg::op_sh2add;
						rvb_pkg::funct3_sh3add: op_o = rvb_pkg::op_sh3add;
						default:                unit_o = rvb_pkg::unit_none;
					endcase
				end
				rvb_pkg::funct7_min: begin
					unit_o = funct3[2] ? rvb_pkg::unit_simple : rvb_pkg::unit_clmul;
					case (funct3)
						rvb_pkg::funct3_clmul:  op_o = rvb_pkg::op_clmul;
						rvb_pkg::funct3_clmulr: op_o = rvb_pkg::op_clmulr;
						rvb_pkg::funct3_clmulh: op_o = rvb_pkg::op_clmulh;
						rvb_pkg::funct3_min:    op_o = rvb_pkg::op_min;
						rvb_pkg::funct3_max:    op_o = rvb_pkg::op_max;
						rvb_pkg::funct3_minu:   op_o = rvb_pkg::op_minu;
						rvb_pkg::funct3_maxu:   op_o = rvb_pkg::op_maxu;
						default:                unit_o = rvb_pkg::unit_none;
					endcase
				end
				default: unit_o = rvb_pkg::unit_none;
			endcase
		end else if (opcode == rvb_pkg::opcode_op_imm && funct7 == rvb_pkg::funct7_count
				&& funct3 == rvb_pkg::funct3_count) begin
			unit_o = rvb_pkg::unit_bitcnt;
			case (rs2)
				rvb_pkg::rs2_clz:   op_o = rvb_pkg::op_clz;
				rvb_pkg::rs2_ctz:   op_o = rvb_pkg::op_ctz;
				rvb_pkg::rs2_pcnt:  op_o = rvb_pkg::op_pcnt;
				rvb_pkg::rs2_sextb: op_o = rvb_pkg::op_sextb;
				rvb_pkg::rs2_sexth: op_o = rvb_pkg::op_sexth;
				default:            unit_o = rvb_pkg::unit_none; // CRC and BMATFLIP
			endcase
		end
	end

endmodule

// ==== src/rvb_pkg.sv ====
package rvb_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [31:0] insn_t;

	localparam logic [6:0] opcode_op     = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;

	localparam logic [6:0] funct7_andn  = 7'b0100000;
	localparam logic [6:0] funct7_shadd = 7'b0010000;
	localparam logic [6:0] funct7_min   = 7'b0000101; // Shared with CLMUL group
	localparam logic [6:0] funct7_count = 7'b0110000;

	localparam logic [2:0] funct3_andn   = 3'b111;
	localparam logic [2:0] funct3_orn    = 3'b110;
	localparam logic [2:0] funct3_xnor   = 3'b100;
	localparam logic [2:0] funct3_sh1add = 3'b010;
	localparam logic [2:0] funct3_sh2add = 3'b100;
	localparam logic [2:0] funct3_sh3add = 3'b110;
	localparam logic [2:0] funct3_clmul  = 3'b001;
	localparam logic [2:0] funct3_clmulr = 3'b010;
	localparam logic [2:0] funct3_clmulh = 3'b011;
	localparam logic [2:0] funct3_min    = 3'b100;
	localparam logic [2:0] funct3_max    = 3'b101;
	localparam logic [2:0] funct3_minu   = 3'b110;
	localparam logic [2:0] funct3_maxu   = 3'b111;
	localparam logic [2:0] funct3_count  = 3'b001;

	localparam logic [4:0] rs2_clz   = 5'b00000;
	localparam logic [4:0] rs2_ctz   = 5'b00001;
	localparam logic [4:0] rs2_pcnt  = 5'b00010;
	localparam logic [4:0] rs2_sextb = 5'b00100;
	localparam logic [4:0] rs2_sexth = 5'b00101;

	typedef enum logic [1:0] {
		unit_none,
		unit_simple,
		unit_bitcnt,
		unit_clmul
	} unit_e;

	typedef enum logic [4:0] {
		op_andn, op_orn, op_xnor,
		op_sh1add, op_sh2add, op_sh3add,
		op_min, op_max, op_minu, op_maxu,
		op_clz, op_ctz, op_pcnt, op_sextb, op_sexth,
		op_clmul, op_clmulh, op_clmulr
	} op_e;

	typedef struct packed {
		unit_e unit;
		op_e   op;
		word_t value1;
		word_t value2;
	} issue_t;

	typedef logic [4:0] clmul_count_t;

endpackage

// ==== src/rvb_result_stage.sv ====
`timescale 1ns/1ps

module rvb_result_stage (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           simple_done_i,
	input  logic           bitcnt_done_i,
	input  logic           clmul_done_i,
	input  rvb_pkg::word_t simple_result_i,
	input  rvb_pkg::word_t bitcnt_result_i,
	input  rvb_pkg::word_t clmul_result_i,
	output logic           take_o,
	input  logic           dout_ready_i,
	output logic           dout_valid_o,
	output rvb_pkg::word_t dout_result_o
);
	logic any_done;

	assign any_done = simple_done_i || bitcnt_done_i || clmul_done_i;
	assign take_o   = !dout_valid_o || dout_ready_i; // Register empty or draining

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			dout_valid_o <= 1'b0;
		end else if (take_o) begin
			dout_valid_o <= any_done;
		end
	end

	always_ff @(posedge clk_i) begin
		if (take_o) begin
			if (simple_done_i) begin
				dout_result_o <= simple_result_i;
			end else if (bitcnt_done_i) begin
				dout_result_o <= bitcnt_result_i;
			end else if (clmul_done_i) begin
				dout_result_o <= clmul_result_i;
			end
		end
	end

	a_one_done: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0({simple_done_i, bitcnt_done_i, clmul_done_i}));

endmodule

// ==== src/rvb_simple.sv ====
`timescale 1ns/1ps

module rvb_simple (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           start_i,
	output logic           start_ready_o,
	input  rvb_pkg::op_e   op_i,
	input  rvb_pkg::word_t value1_i,
	input  rvb_pkg::word_t value2_i,
	input  logic           take_i,
	output logic           done_o,
	output rvb_pkg::word_t result_o
);
	rvb_pkg::word_t result_d;
	logic less_s;
	logic less_u;

	assign start_ready_o = !done_o || take_i;
	assign less_s = $signed(value1_i) < $signed(value2_i);
	assign less_u = value1_i < value2_i;

	always_comb begin
		case (op_i)
			rvb_pkg::op_andn:   result_d = value1_i & ~value2_i;
			rvb_pkg::op_orn:    result_d = value1_i | ~value2_i;
			rvb_pkg::op_xnor:   result_d = ~(value1_i ^ value2_i);
			rvb_pkg::op_sh1add: result_d = (value1_i << 1) + value2_i;
			rvb_pkg::op_sh2add: result_d = (value1_i << 2) + value2_i;
			rvb_pkg::op_sh3add: result_d = (value1_i << 3) + value2_i;
			rvb_pkg::op_min:    result_d = less_s ? value1_i : value2_i;
			rvb_pkg::op_max:    result_d = less_s ? value2_i : value1_i;
			rvb_pkg::op_minu:   result_d = less_u ? value1_i : value2_i;
			default:            result_d = less_u ? value2_i : value1_i; // MAXU
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			done_o <= 1'b0;
		end else if (start_i && start_ready_o) begin
			done_o <= 1'b1;
		end else if (take_i) begin
			done_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i && start_ready_o) begin
			result_o <= result_d;
		end
	end

	a_simple_op: assert property (@(posedge clk_i) disable iff (rst_i)
		start_i |-> op_i inside {[rvb_pkg::op_andn:rvb_pkg::op_maxu]});

endmodule

// ==== src/rvb_unit.sv ====
`timescale 1ns/1ps

module rvb_unit (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           din_valid_i,
	output logic           din_ready_o,
	output logic           din_decoded_o,
	input  rvb_pkg::word_t din_value1_i,
	input  rvb_pkg::word_t din_value2_i,
	input  rvb_pkg::insn_t din_instruction_i,
	output logic           dout_valid_o,
	input  logic           dout_ready_i,
	output rvb_pkg::word_t dout_result_o
);
	rvb_pkg::unit_e  dec_unit;
	rvb_pkg::op_e    dec_op;
	rvb_pkg::issue_t issue_q;
	logic            issue_pending;
	logic            busy_q;
	logic            accept;
	logic            sel_ready;
	logic            take;
	logic            result_taken;
	logic            simple_start, bitcnt_start, clmul_start;
	logic            simple_ready, bitcnt_ready, clmul_ready;
	logic            simple_done, bitcnt_done, clmul_done;
	rvb_pkg::word_t  simple_result, bitcnt_result, clmul_result;

	rvb_decoder u_decoder (
		.insn_i (din_instruction_i),
		.unit_o (dec_unit),
		.op_o   (dec_op)
	);

	assign din_decoded_o = dec_unit != rvb_pkg::unit_none;
	assign din_ready_o   = !rst_i && !busy_q && din_decoded_o;
	assign accept        = din_valid_i && din_ready_o;

	assign simple_start = issue_pending && issue_q.unit == rvb_pkg::unit_simple;
	assign bitcnt_start = issue_pending && issue_q.unit == rvb_pkg::unit_bitcnt;
	assign clmul_start  = issue_pending && issue_q.unit == rvb_pkg::unit_clmul;

	always_comb begin
		case (issue_q.unit)
			rvb_pkg::unit_simple: sel_ready = simple_ready;
			rvb_pkg::unit_bitcnt: sel_ready = bitcnt_ready;
			rvb_pkg::unit_clmul:  sel_ready = clmul_ready;
			default:              sel_ready = 1'b1;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			issue_q <= '{unit: dec_unit, op: dec_op, value1: din_value1_i, value2: din_value2_i};
		end
	end

	assign result_taken = take && (simple_done || bitcnt_done || clmul_done);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			issue_pending <= 1'b0;
			busy_q        <= 1'b0;
		end else begin
			if (accept) begin
				issue_pending <= 1'b1;
				busy_q        <= 1'b1;
			end else if (sel_ready) begin
				issue_pending <= 1'b0; // Unit picked it up
			end
			if (result_taken) begin
				busy_q <= 1'b0;
			end
		end
	end

	rvb_simple u_simple (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.start_i       (simple_start),
		.start_ready_o (simple_ready),
		.op_i          (issue_q.op),
		.value1_i      (issue_q.value1),
		.value2_i      (issue_q.value2),
		.take_i        (take),
		.done_o        (simple_done),
		.result_o      (simple_result)
	);

	rvb_bitcnt u_bitcnt (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.start_i       (bitcnt_start),
		.start_ready_o (bitcnt_ready),
		.op_i          (issue_q.op),
		.value1_i      (issue_q.value1),
		.take_i        (take),
		.done_o        (bitcnt_done),
		.result_o      (bitcnt_result)
	);

	rvb_clmul u_clmul (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.start_i       (clmul_start),
		.start_ready_o (clmul_ready),
		.op_i          (issue_q.op),
		.value1_i      (issue_q.value1),
		.value2_i      (issue_q.value2),
		.take_i        (take),
		.done_o        (clmul_done),
		.result_o      (clmul_result)
	);

	rvb_result_stage u_result_stage (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.simple_done_i   (simple_done),
		.bitcnt_done_i   (bitcnt_done),
		.clmul_done_i    (clmul_done),
		.simple_result_i (simple_result),
		.bitcnt_result_i (bitcnt_result),
		.clmul_result_i  (clmul_result),
		.take_o          (take),
		.dout_ready_i    (dout_ready_i),
		.dout_valid_o    (dout_valid_o),
		.dout_result_o   (dout_result_o)
	);

	// A new instruction finds every unit idle
	a_single_flight: assert property (@(posedge clk_i) disable iff (rst_i)
		accept |-> !issue_pending && !simple_done && !bitcnt_done
			&& !clmul_done && clmul_ready);

endmodule
